// File: logic/lbp_cfg_pkg.sv
`default_nettype none

package lbp_cfg_pkg;

  // ------------------------------------------------------------
  // Predictor geometry defaults
  // ------------------------------------------------------------

  // Width of the virtual fetch address
  localparam int unsigned VaddrWidth = 32;

  // Entries in the local history table
  localparam int unsigned LhrEntries = 64;

  // Local history length, also the pattern table index width
  localparam int unsigned HistBits = 6;

  // Bit 0 of a PC is always zero with compressed instructions
  localparam int unsigned PcOffset = 1;

endpackage : lbp_cfg_pkg

`default_nettype wire

// File: logic/lbp_types_pkg.sv
`default_nettype none

package lbp_types_pkg;

  // ------------------------------------------------------------
  // Saturating counter
  // ------------------------------------------------------------

  localparam int unsigned CtrBits = 2;

  typedef logic [CtrBits-1:0] ctr_t;

  // Strongly taken
  localparam ctr_t CtrMax = ctr_t'((1 << CtrBits) - 1);

  // Weakly taken, only the top bit set
  localparam ctr_t CtrWeakTaken = ctr_t'(1 << (CtrBits - 1));

  // ------------------------------------------------------------
  // Pattern table entry
  // ------------------------------------------------------------

  typedef struct packed {
    logic valid;
    ctr_t ctr;
  } pattern_entry_t;

  // Loaded into every pattern entry on a flush
  localparam pattern_entry_t PatternFlushVal = '{valid: 1'b0, ctr: CtrWeakTaken};

endpackage : lbp_types_pkg

`default_nettype wire

// File: logic/lbp_table.sv
`default_nettype none

module lbp_table #(
  parameter int unsigned Depth    = 64,
  parameter type         entry_t  = logic,
  parameter entry_t      FlushVal = entry_t'('0)
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     flush_i,
  // Combinational read ports
  input  wire logic [$clog2(Depth)-1:0] rd0_addr_i,
  output entry_t                        rd0_data_o,
  input  wire logic [$clog2(Depth)-1:0] rd1_addr_i,
  output entry_t                        rd1_data_o,
  // Write port, lands at the rising edge
  input  wire logic                     we_i,
  input  wire logic [$clog2(Depth)-1:0] wr_addr_i,
  input  entry_t                        wr_data_i
);

  entry_t mem_q [Depth];

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------

  assign rd0_data_o = mem_q[rd0_addr_i];
  assign rd1_data_o = mem_q[rd1_addr_i];

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        mem_q[i] <= entry_t'('0);
      end
    end else if (flush_i) begin
      // Flush wins over a write in the same cycle
      for (int unsigned i = 0; i < Depth; i++) begin
        mem_q[i] <= FlushVal;
      end
    end else if (we_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

endmodule : lbp_table

`default_nettype wire

// File: logic/lbp_history.sv
`default_nettype none

module lbp_history #(
  parameter int unsigned VaddrWidth = lbp_cfg_pkg::VaddrWidth,
  parameter int unsigned LhrEntries = lbp_cfg_pkg::LhrEntries,
  parameter int unsigned HistBits   = lbp_cfg_pkg::HistBits
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  input  wire logic                  debug_mode_i,
  // Fetch side
  input  wire logic [VaddrWidth-1:0] vpc_i,
  output logic      [HistBits-1:0]   fetch_hist_o,
  // Resolved branch update
  input  wire logic                  upd_valid_i,
  input  wire logic [VaddrWidth-1:0] upd_pc_i,
  input  wire logic                  upd_taken_i,
  output logic      [HistBits-1:0]   upd_hist_o,
  output logic                       upd_en_o
);

  import lbp_cfg_pkg::*;

  localparam int unsigned LhrIdxBits = $clog2(LhrEntries);

  typedef logic [HistBits-1:0] hist_t;

  logic [LhrIdxBits-1:0] fetch_idx;
  logic [LhrIdxBits-1:0] upd_idx;
  hist_t                 fetch_hist;
  hist_t                 upd_hist;
  hist_t                 upd_hist_next;

  // ------------------------------------------------------------
  // Index forming
  // ------------------------------------------------------------

  // Skip the low PC bits that never vary
  assign fetch_idx = vpc_i[PcOffset +: LhrIdxBits];
  assign upd_idx   = upd_pc_i[PcOffset +: LhrIdxBits];

  // ------------------------------------------------------------
  // Update gating and history shift
  // ------------------------------------------------------------

  // No training while the core is halted in debug mode
  assign upd_en_o = upd_valid_i & ~debug_mode_i;

  // Newest outcome enters at bit 0
  assign upd_hist_next = {upd_hist[HistBits-2:0], upd_taken_i};

  lbp_table #(
    .Depth    (LhrEntries),
    .entry_t  (hist_t),
    .FlushVal (hist_t'('0))
  ) u_lhr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .rd0_addr_i (fetch_idx),
    .rd0_data_o (fetch_hist),
    .rd1_addr_i (upd_idx),
    .rd1_data_o (upd_hist),
    .we_i       (upd_en_o),
    .wr_addr_i  (upd_idx),
    .wr_data_i  (upd_hist_next)
  );

  assign fetch_hist_o = fetch_hist;
  assign upd_hist_o   = upd_hist;

endmodule : lbp_history

`default_nettype wire

// File: logic/lbp_counter_update.sv
`default_nettype none

module lbp_counter_update (
  // Pattern entry selected by the fetch history
  input  lbp_types_pkg::pattern_entry_t fetch_entry_i,
  output logic                          pred_valid_o,
  output logic                          pred_taken_o,
  // Pattern entry selected by the update history
  input  lbp_types_pkg::pattern_entry_t upd_entry_i,
  input  wire logic                     upd_en_i,
  input  wire logic                     upd_taken_i,
  // Pattern table write port
  output logic                          we_o,
  output lbp_types_pkg::pattern_entry_t wr_data_o
);

  import lbp_types_pkg::*;

  ctr_t ctr_cur;
  ctr_t ctr_next;

  // ------------------------------------------------------------
  // Prediction decode
  // ------------------------------------------------------------

  assign pred_valid_o = fetch_entry_i.valid;
  // Upper half of the counter range means taken
  assign pred_taken_o = fetch_entry_i.ctr[CtrBits-1];

  // ------------------------------------------------------------
  // Saturating counter update
  // ------------------------------------------------------------

  assign ctr_cur = upd_entry_i.ctr;

  always_comb begin
    ctr_next = ctr_cur;
    if (upd_taken_i) begin
      if (ctr_cur != CtrMax) begin
        ctr_next = ctr_cur + ctr_t'(1);
      end
    end else begin
      // Hold at zero on not taken
      if (ctr_cur != ctr_t'(0)) begin
        ctr_next = ctr_cur - ctr_t'(1);
      end
    end
  end

  // Any trained entry becomes valid
  assign we_o            = upd_en_i;
  assign wr_data_o.valid = 1'b1;
  assign wr_data_o.ctr   = ctr_next;

endmodule : lbp_counter_update

`default_nettype wire

// File: logic/lbp_top.sv
`default_nettype none

module lbp_top #(
  parameter int unsigned VaddrWidth = lbp_cfg_pkg::VaddrWidth,
  parameter int unsigned LhrEntries = lbp_cfg_pkg::LhrEntries,
  parameter int unsigned HistBits   = lbp_cfg_pkg::HistBits
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  input  wire logic                  debug_mode_i,
  // Fetch address and its prediction
  input  wire logic [VaddrWidth-1:0] vpc_i,
  output logic                       pred_valid_o,
  output logic                       pred_taken_o,
  // Resolved branch, one-cycle strobe
  input  wire logic                  upd_valid_i,
  input  wire logic [VaddrWidth-1:0] upd_pc_i,
  input  wire logic                  upd_taken_i
);

  import lbp_types_pkg::*;

  // One pattern entry per history value
  localparam int unsigned PatternDepth = 1 << HistBits;

  logic [HistBits-1:0] fetch_hist;
  logic [HistBits-1:0] upd_hist;
  logic                upd_en;
  logic                pattern_we;
  pattern_entry_t      fetch_entry;
  pattern_entry_t      upd_entry;
  pattern_entry_t      pattern_wdata;

  // ------------------------------------------------------------
  // Level one, local history
  // ------------------------------------------------------------

  lbp_history #(
    .VaddrWidth (VaddrWidth),
    .LhrEntries (LhrEntries),
    .HistBits   (HistBits)
  ) u_history (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .vpc_i        (vpc_i),
    .fetch_hist_o (fetch_hist),
    .upd_valid_i  (upd_valid_i),
    .upd_pc_i     (upd_pc_i),
    .upd_taken_i  (upd_taken_i),
    .upd_hist_o   (upd_hist),
    .upd_en_o     (upd_en)
  );

  // ------------------------------------------------------------
  // Level two, pattern counters
  // ------------------------------------------------------------

  lbp_table #(
    .Depth    (PatternDepth),
    .entry_t  (pattern_entry_t),
    .FlushVal (PatternFlushVal)
  ) u_pattern (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .rd0_addr_i (fetch_hist),
    .rd0_data_o (fetch_entry),
    .rd1_addr_i (upd_hist),
    .rd1_data_o (upd_entry),
    .we_i       (pattern_we),
    .wr_addr_i  (upd_hist),
    .wr_data_i  (pattern_wdata)
  );

  lbp_counter_update u_counter (
    .fetch_entry_i (fetch_entry),
    .pred_valid_o  (pred_valid_o),
    .pred_taken_o  (pred_taken_o),
    .upd_entry_i   (upd_entry),
    .upd_en_i      (upd_en),
    .upd_taken_i   (upd_taken_i),
    .we_o          (pattern_we),
    .wr_data_o     (pattern_wdata)
  );

endmodule : lbp_top

`default_nettype wire

// File: tb/lbp_chk.sv
`default_nettype none

module lbp_chk (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic flush_i,
  input wire logic debug_mode_i,
  input wire logic pred_valid_i,
  input wire logic pred_taken_i,
  input wire logic pattern_we_i
);

  // Assertion failures seen so far
  int unsigned fail_count = 0;

  // ------------------------------------------------------------
  // Output sanity
  // ------------------------------------------------------------

  a_pred_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({pred_valid_i, pred_taken_i}))
    else begin
      $error("Prediction outputs are unknown out of reset");
      fail_count++;
    end

  // ------------------------------------------------------------
  // Flush and debug behavior
  // ------------------------------------------------------------

  // Every entry is invalid in the cycle after a flush edge
  a_flush_invalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !pred_valid_i)
    else begin
      $error("Prediction still valid in the cycle after a flush");
      fail_count++;
    end

  a_no_write_in_debug : assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_mode_i |-> !pattern_we_i)
    else begin
      $error("Pattern table written while in debug mode");
      fail_count++;
    end

endmodule : lbp_chk

bind lbp_top lbp_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .flush_i      (flush_i),
  .debug_mode_i (debug_mode_i),
  .pred_valid_i (pred_valid_o),
  .pred_taken_i (pred_taken_o),
  .pattern_we_i (pattern_we)
);

`default_nettype wire

// File: tb/tb_lbp.sv
`default_nettype none

module tb_lbp;

  import lbp_cfg_pkg::*;

  localparam int unsigned LhrIdxBits   = $clog2(LhrEntries);
  localparam int unsigned PatternDepth = 1 << HistBits;
  localparam int unsigned ResetTimeout = 20;
  localparam int unsigned RandomRows   = 200;

  // Two PCs on different history entries, 2 and 4
  localparam logic [VaddrWidth-1:0] PcA = 32'h0000_0104;
  localparam logic [VaddrWidth-1:0] PcB = 32'h0000_0208;

  typedef struct packed {
    logic [VaddrWidth-1:0] vpc;
    logic                  upd_valid;
    logic [VaddrWidth-1:0] upd_pc;
    logic                  taken;
    logic                  debug;
    logic                  flush;
    logic                  chk;
    logic                  exp_valid;
    logic                  exp_taken;
  } row_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  debug_mode_i;
  logic [VaddrWidth-1:0] vpc_i;
  logic                  upd_valid_i;
  logic [VaddrWidth-1:0] upd_pc_i;
  logic                  upd_taken_i;
  logic                  pred_valid_o;
  logic                  pred_taken_o;

  row_t rows [$];
  int   err_count;
  int   timeout_count;

  // Reference state of both tables
  logic [HistBits-1:0] ref_hist [LhrEntries];
  logic                ref_valid [PatternDepth];
  logic [1:0]          ref_ctr [PatternDepth];

  lbp_top #(
    .VaddrWidth (VaddrWidth),
    .LhrEntries (LhrEntries),
    .HistBits   (HistBits)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .vpc_i        (vpc_i),
    .pred_valid_o (pred_valid_o),
    .pred_taken_o (pred_taken_o),
    .upd_valid_i  (upd_valid_i),
    .upd_pc_i     (upd_pc_i),
    .upd_taken_i  (upd_taken_i)
  );

  always #50 clk_i = ~clk_i;

  initial begin
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic int unsigned lhr_index(input logic [VaddrWidth-1:0] pc);
    return int'(pc[PcOffset +: LhrIdxBits]);
  endfunction

  // Applies the inputs that the DUT samples at this edge
  task automatic apply_model();
    int unsigned         idx;
    logic [HistBits-1:0] h;
    if (flush_i) begin
      for (int i = 0; i < LhrEntries; i++) begin
        ref_hist[i] = '0;
      end
      for (int i = 0; i < PatternDepth; i++) begin
        ref_valid[i] = 1'b0;
        ref_ctr[i]   = 2'd2;
      end
    end else if (upd_valid_i && !debug_mode_i) begin
      idx = lhr_index(upd_pc_i);
      h   = ref_hist[idx];
      if (upd_taken_i) begin
        if (ref_ctr[h] != 2'd3) ref_ctr[h] = ref_ctr[h] + 2'd1;
      end else begin
        if (ref_ctr[h] != 2'd0) ref_ctr[h] = ref_ctr[h] - 2'd1;
      end
      ref_valid[h]  = 1'b1;
      ref_hist[idx] = {h[HistBits-2:0], upd_taken_i};
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------------------

  task automatic add_row(input logic [VaddrWidth-1:0] vpc, input logic uv,
                         input logic [VaddrWidth-1:0] upc, input logic tk,
                         input logic dbg, input logic fl, input logic chk,
                         input logic ev, input logic et);
    row_t r;
    r = '{vpc: vpc, upd_valid: uv, upd_pc: upc, taken: tk, debug: dbg, flush: fl,
          chk: chk, exp_valid: ev, exp_taken: et};
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r);
    vpc_i        <= r.vpc;
    upd_valid_i  <= r.upd_valid;
    upd_pc_i     <= r.upd_pc;
    upd_taken_i  <= r.taken;
    debug_mode_i <= r.debug;
    flush_i      <= r.flush;
  endtask

  task automatic check_prediction(input row_t r, input int row_num);
    logic [HistBits-1:0] h;
    logic                exp_v;
    logic                exp_t;
    h     = ref_hist[lhr_index(r.vpc)];
    exp_v = ref_valid[h];
    exp_t = ref_ctr[h][1];
    assert (pred_valid_o === exp_v) else begin
      $display("CHECK FAILED pred_valid_o expected 0x%h actual 0x%h row %0d",
               exp_v, pred_valid_o, row_num);
      err_count++;
    end
    assert (pred_taken_o === exp_t) else begin
      $display("CHECK FAILED pred_taken_o expected 0x%h actual 0x%h row %0d",
               exp_t, pred_taken_o, row_num);
      err_count++;
    end
    // Hand-derived values of the directed rows
    if (r.chk) begin
      assert (pred_valid_o === r.exp_valid) else begin
        $display("CHECK FAILED pred_valid_o expected 0x%h actual 0x%h table row %0d",
                 r.exp_valid, pred_valid_o, row_num);
        err_count++;
      end
      assert (pred_taken_o === r.exp_taken) else begin
        $display("CHECK FAILED pred_taken_o expected 0x%h actual 0x%h table row %0d",
                 r.exp_taken, pred_taken_o, row_num);
        err_count++;
      end
    end
  endtask

  task automatic run_step(input row_t r, input int row_num);
    @(posedge clk_i);
    apply_model();
    drive_row(r);
    @(negedge clk_i);
    check_prediction(r, row_num);
  endtask

  task automatic random_row(output row_t r);
    r.vpc       = ($urandom & 32'hFFFF_FF80) | ($urandom & 32'h0000_001E);
    r.upd_valid = (($urandom % 4) != 0);
    r.upd_pc    = ($urandom & 32'hFFFF_FF80) | ($urandom & 32'h0000_001E);
    r.taken     = (($urandom % 2) != 0);
    r.debug     = (($urandom % 8) == 0);
    r.flush     = (($urandom % 32) == 0);
    r.chk       = 1'b0;
    r.exp_valid = 1'b0;
    r.exp_taken = 1'b0;
  endtask

  task automatic wait_reset_release(output logic released);
    released = 1'b0;
    for (int i = 0; i < ResetTimeout && !released; i++) begin
      @(negedge clk_i);
      if (rst_ni === 1'b1) released = 1'b1;
    end
  endtask

  task automatic build_table();
    // Reset state
    add_row(PcA, 0, PcA, 0, 0, 0, 1, 0, 0);
    add_row(PcB, 0, PcB, 0, 0, 0, 1, 0, 0);
    // Train PcA taken up to an all-ones history
    for (int i = 0; i < HistBits + 2; i++) add_row(PcA, 1, PcA, 1, 0, 0, 0, 0, 0);
    add_row(PcA, 0, PcA, 0, 0, 0, 1, 1, 1);
    // Extra taken updates at the maximum
    for (int i = 0; i < 2; i++) add_row(PcA, 1, PcA, 1, 0, 0, 0, 0, 0);
    add_row(PcA, 0, PcA, 0, 0, 0, 1, 1, 1);
    // Not taken on PcB drives pattern 0 down to zero and holds
    for (int i = 0; i < 3; i++) add_row(PcB, 1, PcB, 0, 0, 0, 0, 0, 0);
    add_row(PcB, 0, PcB, 0, 0, 0, 1, 1, 0);
    // Not-taken updates in debug mode change nothing
    for (int i = 0; i < 3; i++) add_row(PcA, 1, PcA, 0, 1, 0, 0, 0, 0);
    add_row(PcB, 0, PcB, 0, 0, 0, 1, 1, 0);
    add_row(PcA, 0, PcA, 0, 0, 0, 1, 1, 1);
    // Alternating pattern replayed on PcB
    for (int i = 0; i < 8; i++) add_row(PcB, 1, PcB, i % 2 == 0, 0, 0, 0, 0, 0);
    // Flush, with a same-cycle update that must be dropped
    add_row(PcA, 1, PcA, 1, 0, 1, 0, 0, 0);
    add_row(PcA, 0, PcA, 0, 0, 0, 1, 0, 1);
    add_row(PcB, 0, PcB, 0, 0, 0, 1, 0, 1);
    add_row(PcA, 1, PcA, 0, 0, 0, 1, 0, 1);
    add_row(PcA, 0, PcA, 0, 0, 0, 1, 1, 0);
    add_row(PcB, 0, PcB, 0, 0, 0, 1, 1, 0);
  endtask

  initial begin
    int unsigned seed;
    int unsigned dummy;
    int unsigned chk_fails;
    logic        released;
    row_t        r;
    seed          = 3;
    dummy         = $urandom(seed);
    err_count     = 0;
    timeout_count = 0;
    clk_i         = 1'b0;
    flush_i       = 1'b0;
    debug_mode_i  = 1'b0;
    vpc_i         = '0;
    upd_valid_i   = 1'b0;
    upd_pc_i      = '0;
    upd_taken_i   = 1'b0;
    for (int i = 0; i < LhrEntries; i++) ref_hist[i] = '0;
    for (int i = 0; i < PatternDepth; i++) begin
      ref_valid[i] = 1'b0;
      ref_ctr[i]   = 2'd0;
    end
    build_table();

    wait_reset_release(released);
    if (!released) begin
      $display("Reset was not released within %0d cycles", ResetTimeout);
      timeout_count++;
    end else begin
      foreach (rows[i]) run_step(rows[i], i);
      for (int i = 0; i < RandomRows; i++) begin
        random_row(r);
        run_step(r, rows.size() + i);
      end
    end

    chk_fails = u_dut.u_chk.fail_count;
    $display("Errors: %0d check failures, %0d assertion failures, %0d timeouts",
             err_count, chk_fails, timeout_count);
    if (err_count == 0 && chk_fails == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_lbp

`default_nettype wire

// File: flist.f
logic/lbp_cfg_pkg.sv
logic/lbp_types_pkg.sv
logic/lbp_table.sv
logic/lbp_history.sv
logic/lbp_counter_update.sv
logic/lbp_top.sv
tb/lbp_chk.sv
tb/tb_lbp.sv

// File: Bender.yml
package:
  name: lbp

sources:
  # Packages first, the RTL depends on them
  - logic/lbp_cfg_pkg.sv
  - logic/lbp_types_pkg.sv
  # RTL
  - logic/lbp_table.sv
  - logic/lbp_history.sv
  - logic/lbp_counter_update.sv
  - logic/lbp_top.sv
  # Testbench
  - target: test
    files:
      - tb/lbp_chk.sv
      - tb/tb_lbp.sv
